// ==== bench/sb_properties.sv ====
// port-level protocol checks, bound into every scoreboard_top instance
`timescale 1ns/100ps

module sb_properties import sb_pkg::*; #(
  parameter int unsigned NrWbPorts = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            issue_ack_i,
  input  logic                            issue_valid_o,
  input  logic      [NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  sb_entry_t [NR_COMMIT_PORTS-1:0] commit_instr_o,
  input  wb_port_t  [NrWbPorts-1:0]       wb_i,
  input  fu_t       [NR_REGS-1:0]         rd_clobber_o
);

  // x0 never has a pending writer
  a_x0_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o[0] == FU_NONE) else $error("register 0 shows a pending writer");

  // issue stage only acks an offered instruction
  a_issue_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o) else $error("issue ack without issue valid");

  // commit acks need a finished entry behind them
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : g_commit
    a_commit_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[i] |-> commit_instr_o[i].valid) else $error("commit ack on invalid entry");
  end

  // each trans id has one producer per cycle
  for (genvar a = 0; a < NrWbPorts; a++) begin : g_wb_a
    for (genvar b = a + 1; b < NrWbPorts; b++) begin : g_wb_b
      a_wb_distinct: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_i[a].valid && wb_i[b].valid) |-> (wb_i[a].trans_id != wb_i[b].trans_id))
        else $error("two write-back ports name the same trans id");
    end
  end

endmodule

bind scoreboard_top sb_properties #(.NrWbPorts(NrWbPorts)) u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .issue_ack_i    (issue_ack_i),
  .issue_valid_o  (issue_valid_o),
  .commit_ack_i   (commit_ack_i),
  .commit_instr_o (commit_instr_o),
  .wb_i           (wb_i),
  .rd_clobber_o   (rd_clobber_o)
);

// ==== bench/tb_scoreboard.sv ====
// random testbench for the scoreboard, checks every output each cycle against a slot model
`timescale 1ns/100ps

module tb_scoreboard import sb_pkg::*; ();

  localparam int unsigned NrWb         = 2;
  localparam int unsigned NumCycles    = 2000;
  localparam int unsigned DrainTimeout = 500;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             flush_i;
  sb_entry_t                        decoded_instr_i;
  logic                             decoded_valid_i;
  logic                             decoded_ack_o;
  trans_id_t                        decoded_ptr_o;
  sb_entry_t                        issue_instr_o;
  logic                             issue_valid_o;
  logic                             issue_ack_i;
  logic                             unresolved_branch_i;
  logic                             sb_full_o;
  wb_port_t  [NrWb-1:0]             wb_i;
  sb_entry_t [NR_COMMIT_PORTS-1:0]  commit_instr_o;
  logic      [NR_COMMIT_PORTS-1:0]  commit_ack_i;
  fu_t       [NR_REGS-1:0]          rd_clobber_o;
  reg_addr_t                        rs1_i;
  reg_addr_t                        rs2_i;
  xlen_t                            rs1_o;
  xlen_t                            rs2_o;
  logic                             rs1_valid_o;
  logic                             rs2_valid_o;

  // reference state of the queue
  sb_slot_t [NR_ENTRIES-1:0] m_slot;
  trans_id_t                 m_issue_ptr;
  trans_id_t                 m_commit_ptr;
  int unsigned               m_cnt;
  logic                      flush_seen;
  int                        seed;
  int unsigned               waited;

  scoreboard_top #(.NrWbPorts(NrWb)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %0t %s expected=%h actual=%h", $time, name, exp, act);
      stop_run("output mismatch against the reference model");
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  // applies the inputs seen at this edge to the mirrored slots
  task automatic model_step();
    sb_slot_t [NR_ENTRIES-1:0] nxt;
    trans_id_t                 idx;
    logic                      issue_en;
    int unsigned               ncommit;
    nxt      = m_slot;
    ncommit  = 0;
    issue_en = decoded_valid_i && issue_ack_i && (m_cnt != NR_ENTRIES);
    if (issue_en) begin
      nxt[m_issue_ptr].issued         = 1'b1;
      nxt[m_issue_ptr].entry          = decoded_instr_i;
      nxt[m_issue_ptr].entry.valid    = 1'b0;
      nxt[m_issue_ptr].entry.ex_valid = 1'b0;
      nxt[m_issue_ptr].entry.trans_id = m_issue_ptr;
    end
    // units with nothing to compute finish one edge after landing
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (m_slot[i].issued && m_slot[i].entry.fu == FU_NONE) nxt[i].entry.valid = 1'b1;
    end
    // results only count for occupied slots
    for (int unsigned k = 0; k < NrWb; k++) begin
      if (wb_i[k].valid && m_slot[wb_i[k].trans_id].issued) begin
        nxt[wb_i[k].trans_id].entry.valid    = 1'b1;
        nxt[wb_i[k].trans_id].entry.result   = wb_i[k].data;
        nxt[wb_i[k].trans_id].entry.ex_valid = wb_i[k].ex_valid;
      end
    end
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      if (commit_ack_i[i]) begin
        idx = m_commit_ptr + trans_id_t'(i);
        nxt[idx].issued         = 1'b0;
        nxt[idx].entry.valid    = 1'b0;
        nxt[idx].entry.ex_valid = 1'b0;
        ncommit++;
      end
    end
    if (flush_i) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        nxt[i].issued         = 1'b0;
        nxt[i].entry.valid    = 1'b0;
        nxt[i].entry.ex_valid = 1'b0;
      end
      m_issue_ptr  = '0;
      m_commit_ptr = '0;
      m_cnt        = 0;
      flush_seen   = 1'b1;
    end else begin
      m_issue_ptr  = m_issue_ptr + trans_id_t'(issue_en);
      m_commit_ptr = m_commit_ptr + trans_id_t'(ncommit);
      m_cnt        = m_cnt + int'(issue_en) - ncommit;
      if (issue_en) flush_seen = 1'b0;
    end
    m_slot = nxt;
  endtask

  // write-back ports first, lowest port wins, then finished slots by index
  task automatic expect_fwd(input reg_addr_t rs, output logic v, output xlen_t d);
    v = 1'b0;
    d = '0;
    for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
      if (m_slot[i].issued && m_slot[i].entry.valid && m_slot[i].entry.rd == rs) begin
        v = 1'b1;
        d = m_slot[i].entry.result;
      end
    end
    for (int k = NrWb - 1; k >= 0; k--) begin
      if (wb_i[k].valid && !wb_i[k].ex_valid && m_slot[wb_i[k].trans_id].entry.rd == rs) begin
        v = 1'b1;
        d = wb_i[k].data;
      end
    end
    if (rs == '0) v = 1'b0;
  endtask

  // --------------------
  // stimulus
  // --------------------
  task automatic drive_inputs(input logic allow_issue);
    logic [31:0]           r;
    logic [31:0]           r2;
    logic [NR_ENTRIES-1:0] used;
    trans_id_t             idx;
    logic                  full;
    full = (m_cnt == NR_ENTRIES);
    r    = rnd();
    r2   = rnd();
    decoded_valid_i          = allow_issue && (r[1:0] != 2'd0);
    unresolved_branch_i      = (r[4:2] == 3'd0);
    // ack only what issue is offering
    issue_ack_i              = decoded_valid_i && !unresolved_branch_i && !full && (r[6:5] != 2'd0);
    decoded_instr_i.fu       = fu_t'(3'(r2 % 6));
    // narrow rd half the time so hazards and forwarding hits are common
    decoded_instr_i.rd       = r2[8] ? reg_addr_t'(r2[5:3]) : r2[13:9];
    decoded_instr_i.valid    = r2[14];
    decoded_instr_i.ex_valid = r2[15];
    decoded_instr_i.trans_id = r2[18:16];
    decoded_instr_i.result   = rnd();
    // in-order acks on finished entries only
    idx             = m_commit_ptr + trans_id_t'(1);
    commit_ack_i[0] = m_slot[m_commit_ptr].entry.valid && r[7];
    commit_ack_i[1] = commit_ack_i[0] && m_slot[idx].entry.valid && r[8];
    flush_i         = (r[14:9] == 6'd0);
    rs1_i           = r[15] ? reg_addr_t'(r[18:16]) : r[23:19];
    rs2_i           = r[24] ? reg_addr_t'(r[27:25]) : r[31:27];
    used = '0;
    for (int unsigned k = 0; k < NrWb; k++) begin
      r                 = rnd();
      idx               = r[2:0];
      wb_i[k].valid     = 1'b0;
      wb_i[k].trans_id  = idx;
      wb_i[k].ex_valid  = (r[7:4] == 4'd0);
      wb_i[k].data      = rnd();
      if (!used[idx] && m_slot[idx].issued && m_slot[idx].entry.fu != FU_NONE &&
          !m_slot[idx].entry.valid && r[3]) begin
        wb_i[k].valid = 1'b1;
      end else if (!used[idx] && !m_slot[idx].issued && r[10:8] == 3'd0) begin
        // late answer for a freed slot
        wb_i[k].valid = 1'b1;
      end
      if (wb_i[k].valid) used[idx] = 1'b1;
    end
  endtask

  // --------------------
  // checks
  // --------------------
  task automatic check_outputs();
    logic      full;
    logic      accept;
    trans_id_t idx;
    sb_entry_t e;
    fu_t       exp_fu;
    logic      v;
    xlen_t     d;
    full   = (m_cnt == NR_ENTRIES);
    accept = decoded_valid_i && issue_ack_i && !full;
    check_val("sb_full_o", 32'(full), 32'(sb_full_o));
    check_val("issue_valid_o", 32'(decoded_valid_i && !unresolved_branch_i && !full),
              32'(issue_valid_o));
    check_val("decoded_ack_o", 32'(issue_ack_i && !full), 32'(decoded_ack_o));
    idx = flush_i ? trans_id_t'(0) : m_issue_ptr + trans_id_t'(accept);
    check_val("decoded_ptr_o", 32'(idx), 32'(decoded_ptr_o));
    check_val("issue_instr_o.trans_id", 32'(m_issue_ptr), 32'(issue_instr_o.trans_id));
    // issue view passes the decoded record through unchanged
    check_val("issue_instr_o.fu", 32'(decoded_instr_i.fu), 32'(issue_instr_o.fu));
    check_val("issue_instr_o.rd", 32'(decoded_instr_i.rd), 32'(issue_instr_o.rd));
    check_val("issue_instr_o.result", decoded_instr_i.result, issue_instr_o.result);
    check_val("issue_instr_o.valid", 32'(decoded_instr_i.valid), 32'(issue_instr_o.valid));
    check_val("issue_instr_o.ex_valid", 32'(decoded_instr_i.ex_valid),
              32'(issue_instr_o.ex_valid));
    // first instruction after a flush must land in slot 0
    if (flush_seen && accept) begin
      check_val("issue_instr_o.trans_id", 32'd0, 32'(issue_instr_o.trans_id));
    end
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      idx = m_commit_ptr + trans_id_t'(i);
      e   = m_slot[idx].entry;
      check_val($sformatf("commit_instr_o[%0d].valid", i), 32'(e.valid),
                32'(commit_instr_o[i].valid));
      if (e.valid) begin
        check_val($sformatf("commit_instr_o[%0d].fu", i), 32'(e.fu), 32'(commit_instr_o[i].fu));
        check_val($sformatf("commit_instr_o[%0d].rd", i), 32'(e.rd), 32'(commit_instr_o[i].rd));
        check_val($sformatf("commit_instr_o[%0d].result", i), e.result,
                  commit_instr_o[i].result);
        check_val($sformatf("commit_instr_o[%0d].ex_valid", i), 32'(e.ex_valid),
                  32'(commit_instr_o[i].ex_valid));
        check_val($sformatf("commit_instr_o[%0d].trans_id", i), 32'(idx),
                  32'(commit_instr_o[i].trans_id));
      end
    end
    // lowest issued slot naming the register, x0 stays free
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      exp_fu = FU_NONE;
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (r != 0 && m_slot[i].issued && m_slot[i].entry.rd == reg_addr_t'(r)) begin
          exp_fu = m_slot[i].entry.fu;
        end
      end
      check_val($sformatf("rd_clobber_o[%0d]", r), 32'(exp_fu), 32'(rd_clobber_o[r]));
    end
    expect_fwd(rs1_i, v, d);
    check_val("rs1_valid_o", 32'(v), 32'(rs1_valid_o));
    if (v) check_val("rs1_o", d, rs1_o);
    expect_fwd(rs2_i, v, d);
    check_val("rs2_valid_o", 32'(v), 32'(rs2_valid_o));
    if (v) check_val("rs2_o", d, rs2_o);
  endtask

  // sample at the edge, drive 1 ns later, check mid cycle
  task automatic run_cycle(input logic allow_issue);
    @(posedge clk_i);
    #1;
    model_step();
    drive_inputs(allow_issue);
    #4;
    check_outputs();
  endtask

  initial begin
    seed                = 32'h47ea_abf6;
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    decoded_instr_i     = '0;
    decoded_valid_i     = 1'b0;
    issue_ack_i         = 1'b0;
    unresolved_branch_i = 1'b0;
    wb_i                = '0;
    commit_ack_i        = '0;
    rs1_i               = '0;
    rs2_i               = '0;
    m_slot              = '0;
    m_issue_ptr         = '0;
    m_commit_ptr        = '0;
    m_cnt               = 0;
    flush_seen          = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int unsigned n = 0; n < NumCycles; n++) begin
      run_cycle(1'b1);
    end
    // no new issues, wait for the queue to empty
    waited = 0;
    while (m_cnt != 0 && waited < DrainTimeout) begin
      run_cycle(1'b0);
      waited++;
    end
    if (m_cnt != 0) begin
      stop_run("timeout while waiting for the queue to drain");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// ==== hw/sb_clobber.sv ====
// per-register table of the unit that will write it next, read by issue to hold back hazards
`timescale 1ns/100ps

module sb_clobber import sb_pkg::*; (
  input  sb_slot_t [NR_ENTRIES-1:0] slots_i,
  output fu_t      [NR_REGS-1:0]    rd_clobber_o
);

  // one request bit per register and slot
  logic [NR_REGS-1:0][NR_ENTRIES-1:0] clobber_req;

  // --------------------
  // requests
  // --------------------
  always_comb begin
    clobber_req = '0;
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        clobber_req[r][i] = slots_i[i].issued &&
                            (slots_i[i].entry.rd == reg_addr_t'(r));
      end
    end
    // x0 is never written
    clobber_req[0] = '0;
  end

  // --------------------
  // fixed priority
  // --------------------
  always_comb begin
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      // no request leaves the register free
      rd_clobber_o[r] = FU_NONE;
      // walk from the top so the lowest slot index wins
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (clobber_req[r][i]) begin
          rd_clobber_o[r] = slots_i[i].entry.fu;
        end
      end
    end
  end

endmodule

// ==== hw/sb_ctrl.sv ====
// queue pointers and occupancy for the scoreboard, decides when decode may issue and how far commit moves
`timescale 1ns/100ps

module sb_ctrl import sb_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       decoded_valid_i,
  input  logic                       unresolved_branch_i,
  input  logic                       issue_ack_i,
  input  logic [NR_COMMIT_PORTS-1:0] commit_ack_i,
  output logic                       issue_en_o,
  output trans_id_t                  issue_ptr_o,
  output trans_id_t                  commit_ptr_o,
  output trans_id_t                  decoded_ptr_o,
  output logic                       issue_valid_o,
  output logic                       decoded_ack_o,
  output logic                       full_o
);

  trans_id_t issue_ptr_q, issue_ptr_n;
  trans_id_t commit_ptr_q, commit_ptr_n;
  cnt_t      cnt_q, cnt_n;
  cnt_t      num_commit;

  // --------------------
  // issue gating
  // --------------------
  // depth is a power of two, so the count msb alone means full
  assign full_o = cnt_q[TRANS_ID_BITS];

  // hold back while a branch is unresolved or no slot is free
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~full_o;
  assign decoded_ack_o = issue_ack_i & ~full_o;

  // handshake done, the record goes into the slot at the issue pointer
  assign issue_en_o = decoded_valid_i & decoded_ack_o;

  // --------------------
  // commit count
  // --------------------
  // commit acks are in order, so their sum is how far the pointer moves
  always_comb begin
    num_commit = '0;
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      num_commit = num_commit + cnt_t'(commit_ack_i[i]);
    end
  end

  // --------------------
  // next state
  // --------------------
  always_comb begin
    issue_ptr_n  = issue_ptr_q + trans_id_t'(issue_en_o);
    commit_ptr_n = commit_ptr_q + trans_id_t'(num_commit);
    cnt_n        = cnt_q - num_commit + cnt_t'(issue_en_o);
    // flush overrides any issue or commit in the same cycle
    if (flush_i) begin
      issue_ptr_n  = '0;
      commit_ptr_n = '0;
      cnt_n        = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      cnt_q        <= cnt_n;
    end
  end

  assign issue_ptr_o   = issue_ptr_q;
  assign commit_ptr_o  = commit_ptr_q;
  // decode sees the id its next instruction will get
  assign decoded_ptr_o = issue_ptr_n;

endmodule

// ==== hw/sb_entry_store.sv ====
// slot array of the scoreboard, written by issue, write-back and commit and read by all other blocks
`timescale 1ns/100ps

module sb_entry_store import sb_pkg::*; #(
  parameter int unsigned NrWbPorts = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  issue_en_i,
  input  trans_id_t                             issue_ptr_i,
  input  sb_entry_t                             decoded_instr_i,
  input  wb_port_t  [NrWbPorts-1:0]             wb_i,
  input  trans_id_t                             commit_ptr_i,
  input  logic      [NR_COMMIT_PORTS-1:0]       commit_ack_i,
  output sb_slot_t  [NR_ENTRIES-1:0]            slots_o,
  output sb_entry_t [NR_COMMIT_PORTS-1:0]       commit_instr_o
);

  sb_slot_t  [NR_ENTRIES-1:0]      mem_q, mem_n;
  trans_id_t [NR_COMMIT_PORTS-1:0] commit_idx;

  // commit port i looks i slots past the commit pointer, wrapping
  always_comb begin
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      commit_idx[i] = commit_ptr_i + trans_id_t'(i);
    end
  end

  always_comb begin
    mem_n = mem_q;

    // --------------------
    // issue
    // --------------------
    // result and exception start empty, the slot index is the id
    if (issue_en_i) begin
      mem_n[issue_ptr_i].issued         = 1'b1;
      mem_n[issue_ptr_i].entry          = decoded_instr_i;
      mem_n[issue_ptr_i].entry.valid    = 1'b0;
      mem_n[issue_ptr_i].entry.ex_valid = 1'b0;
      mem_n[issue_ptr_i].entry.trans_id = issue_ptr_i;
    end

    // --------------------
    // fu none
    // --------------------
    // nothing will write these back, finish them one cycle after they land
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (mem_q[i].issued && mem_q[i].entry.fu == FU_NONE) begin
        mem_n[i].entry.valid = 1'b1;
      end
    end

    // --------------------
    // write-back
    // --------------------
    // a unit may still answer for a slot freed by flush, drop that
    for (int unsigned k = 0; k < NrWbPorts; k++) begin
      if (wb_i[k].valid && mem_q[wb_i[k].trans_id].issued) begin
        mem_n[wb_i[k].trans_id].entry.valid    = 1'b1;
        mem_n[wb_i[k].trans_id].entry.result   = wb_i[k].data;
        mem_n[wb_i[k].trans_id].entry.ex_valid = wb_i[k].ex_valid;
      end
    end

    // --------------------
    // commit
    // --------------------
    // acked instructions leave the queue
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      if (commit_ack_i[i]) begin
        mem_n[commit_idx[i]].issued         = 1'b0;
        mem_n[commit_idx[i]].entry.valid    = 1'b0;
        mem_n[commit_idx[i]].entry.ex_valid = 1'b0;
      end
    end

    // flush last so it wins over everything above
    if (flush_i) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        mem_n[i].issued         = 1'b0;
        mem_n[i].entry.valid    = 1'b0;
        mem_n[i].entry.ex_valid = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_n;
    end
  end

  // commit views straight from the registered slots
  always_comb begin
    for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
      commit_instr_o[i]          = mem_q[commit_idx[i]].entry;
      commit_instr_o[i].trans_id = commit_idx[i];
    end
  end

  assign slots_o = mem_q;

endmodule

// ==== hw/sb_operand_fwd.sv ====
// register-file style lookup that forwards rs1 and rs2 from results not yet committed
`timescale 1ns/100ps

module sb_operand_fwd import sb_pkg::*; #(
  parameter int unsigned NrWbPorts = 2
) (
  input  sb_slot_t [NR_ENTRIES-1:0] slots_i,
  input  wb_port_t [NrWbPorts-1:0]  wb_i,
  input  reg_addr_t                 rs1_i,
  input  reg_addr_t                 rs2_i,
  output xlen_t                     rs1_o,
  output xlen_t                     rs2_o,
  output logic                      rs1_valid_o,
  output logic                      rs2_valid_o
);

  // write-back ports sit below the slots, so they take priority
  localparam int unsigned NumReq = NrWbPorts + NR_ENTRIES;

  typedef struct packed {
    logic  valid;
    xlen_t data;
  } fwd_sel_t;

  logic  [NumReq-1:0] rs1_req, rs2_req;
  xlen_t [NumReq-1:0] fwd_data;
  fwd_sel_t           rs1_sel, rs2_sel;

  // lowest set request wins, scanned from the top
  function automatic fwd_sel_t pick(input logic [NumReq-1:0] req,
                                    input xlen_t [NumReq-1:0] data);
    fwd_sel_t sel;
    sel = '0;
    for (int i = NumReq - 1; i >= 0; i--) begin
      if (req[i]) begin
        sel.valid = 1'b1;
        sel.data  = data[i];
      end
    end
    return sel;
  endfunction

  // --------------------
  // match requests
  // --------------------
  always_comb begin
    // results on the bus this cycle, exceptions carry no usable data
    for (int unsigned k = 0; k < NrWbPorts; k++) begin
      rs1_req[k]  = wb_i[k].valid && !wb_i[k].ex_valid &&
                    (slots_i[wb_i[k].trans_id].entry.rd == rs1_i);
      rs2_req[k]  = wb_i[k].valid && !wb_i[k].ex_valid &&
                    (slots_i[wb_i[k].trans_id].entry.rd == rs2_i);
      fwd_data[k] = wb_i[k].data;
    end
    // finished slots still waiting for commit
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      rs1_req[NrWbPorts+i]  = slots_i[i].issued && slots_i[i].entry.valid &&
                              (slots_i[i].entry.rd == rs1_i);
      rs2_req[NrWbPorts+i]  = slots_i[i].issued && slots_i[i].entry.valid &&
                              (slots_i[i].entry.rd == rs2_i);
      fwd_data[NrWbPorts+i] = slots_i[i].entry.result;
    end
  end

  // --------------------
  // select
  // --------------------
  assign rs1_sel = pick(rs1_req, fwd_data);
  assign rs2_sel = pick(rs2_req, fwd_data);

  assign rs1_o = rs1_sel.data;
  assign rs2_o = rs2_sel.data;
  // x0 reads as the register file's zero, never forwarded
  assign rs1_valid_o = rs1_sel.valid & (|rs1_i);
  assign rs2_valid_o = rs2_sel.valid & (|rs2_i);

endmodule

// ==== hw/sb_pkg.sv ====
// shared widths, functional-unit encoding and record types, imported by every scoreboard module
package sb_pkg;

  // --------------------
  // sizes
  // --------------------
  // register data width
  localparam int unsigned XLEN            = 32;
  // queue depth, power of two so trans ids wrap cleanly
  localparam int unsigned NR_ENTRIES      = 8;
  localparam int unsigned TRANS_ID_BITS   = $clog2(NR_ENTRIES);
  // in-order commit width
  localparam int unsigned NR_COMMIT_PORTS = 2;
  // architectural register file
  localparam int unsigned REG_ADDR_BITS   = 5;
  localparam int unsigned NR_REGS         = 2 ** REG_ADDR_BITS;

  // --------------------
  // base types
  // --------------------
  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  // extra top bit flags a full queue
  typedef logic [TRANS_ID_BITS:0]   cnt_t;

  // unit that will produce the result, FU_NONE finishes on its own
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_LOAD,
    FU_STORE,
    FU_MULT,
    FU_BRANCH
  } fu_t;

  // --------------------
  // records
  // --------------------
  // one tracked instruction
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    logic      valid;     // result present
    logic      ex_valid;  // unit reported an exception
    trans_id_t trans_id;
  } sb_entry_t;

  // queue slot, issued marks it occupied
  typedef struct packed {
    logic      issued;
    sb_entry_t entry;
  } sb_slot_t;

  // result bus from one functional unit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
    logic      ex_valid;
  } wb_port_t;

endpackage

// ==== hw/scoreboard_top.sv ====
// instruction scoreboard top, tracks issued instructions from decode to in-order commit
`timescale 1ns/100ps

module scoreboard_top import sb_pkg::*; #(
  parameter int unsigned NrWbPorts = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  // decode side
  input  sb_entry_t                       decoded_instr_i,
  input  logic                            decoded_valid_i,
  output logic                            decoded_ack_o,
  output trans_id_t                       decoded_ptr_o,
  // issue side
  output sb_entry_t                       issue_instr_o,
  output logic                            issue_valid_o,
  input  logic                            issue_ack_i,
  input  logic                            unresolved_branch_i,
  output logic                            sb_full_o,
  // write-back side
  input  wb_port_t  [NrWbPorts-1:0]       wb_i,
  // commit side
  output sb_entry_t [NR_COMMIT_PORTS-1:0] commit_instr_o,
  input  logic      [NR_COMMIT_PORTS-1:0] commit_ack_i,
  // hazard and operand side
  output fu_t       [NR_REGS-1:0]         rd_clobber_o,
  input  reg_addr_t                       rs1_i,
  output xlen_t                           rs1_o,
  output logic                            rs1_valid_o,
  input  reg_addr_t                       rs2_i,
  output xlen_t                           rs2_o,
  output logic                            rs2_valid_o
);

  logic                      issue_en;
  trans_id_t                 issue_ptr;
  trans_id_t                 commit_ptr;
  sb_slot_t [NR_ENTRIES-1:0] slots;

  // issue sees the decoded record tagged with its future slot
  assign issue_instr_o = '{fu:       decoded_instr_i.fu,
                           rd:       decoded_instr_i.rd,
                           result:   decoded_instr_i.result,
                           valid:    decoded_instr_i.valid,
                           ex_valid: decoded_instr_i.ex_valid,
                           trans_id: issue_ptr};

  // --------------------
  // control
  // --------------------
  sb_ctrl u_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .decoded_valid_i     (decoded_valid_i),
    .unresolved_branch_i (unresolved_branch_i),
    .issue_ack_i         (issue_ack_i),
    .commit_ack_i        (commit_ack_i),
    .issue_en_o          (issue_en),
    .issue_ptr_o         (issue_ptr),
    .commit_ptr_o        (commit_ptr),
    .decoded_ptr_o       (decoded_ptr_o),
    .issue_valid_o       (issue_valid_o),
    .decoded_ack_o       (decoded_ack_o),
    .full_o              (sb_full_o)
  );

  // --------------------
  // datapath
  // --------------------
  sb_entry_store #(
    .NrWbPorts (NrWbPorts)
  ) u_store (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .issue_en_i      (issue_en),
    .issue_ptr_i     (issue_ptr),
    .decoded_instr_i (decoded_instr_i),
    .wb_i            (wb_i),
    .commit_ptr_i    (commit_ptr),
    .commit_ack_i    (commit_ack_i),
    .slots_o         (slots),
    .commit_instr_o  (commit_instr_o)
  );

  sb_clobber u_clobber (
    .slots_i      (slots),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd #(
    .NrWbPorts (NrWbPorts)
  ) u_fwd (
    .slots_i     (slots),
    .wb_i        (wb_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_scoreboard \
  -f tb.f \
  -o sim_tb

sim_status=0
./obj_dir/sim_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "Simulation completed successfully" sim.log; then
  echo "FAIL: simulation ended without passing"
  exit 1
fi
echo "PASS"

// ==== tb.f ====
hw/sb_pkg.sv
hw/sb_ctrl.sv
hw/sb_entry_store.sv
hw/sb_clobber.sv
hw/sb_operand_fwd.sv
hw/scoreboard_top.sv
bench/sb_properties.sv
bench/tb_scoreboard.sv
